// ==== src.f ====
+incdir+include
src/spi_pkg.sv
src/spi_ctrl_if.sv
src/spi_sclk_timer.sv
src/spi_fsm.sv
src/spi_shifter.sv
src/spi_master.sv
tests/spi_checker.sv
tests/spi_properties.sv
tests/spi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module spi_tb -o spi_sim

out=$(./obj_dir/spi_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

// ==== tests/spi_tb.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_tb;

	localparam int num_rows = 9;
	localparam int busy_timeout = 2000;

	logic				clk;
	logic				reset_n;
	logic				start;
	logic				bits16;
	logic [1:0]			mode;
	logic [`SPI_DATA_BITS-1:0]	data_in;
	logic [`SPI_RATIO_BITS-1:0]	clk_cnt;
	logic				MISO = 1'b0;
	logic [`SPI_DATA_BITS-1:0]	data_out;
	logic				busy;
	logic				SEN;
	logic				SCLK;
	logic				MOSI;

	// Stimulus table, last row filled with random words
	logic [`SPI_DATA_BITS-1:0]	tx_tbl [num_rows];
	logic [`SPI_DATA_BITS-1:0]	resp_tbl [num_rows];
	logic [1:0]			mode_tbl [num_rows];
	logic				bits_tbl [num_rows];
	logic [`SPI_RATIO_BITS-1:0]	cnt_tbl [num_rows];

	logic [`SPI_DATA_BITS-1:0]	cur_resp = '0;
	logic [1:0]			cur_mode = 2'b00;
	logic				cur_bits16 = 1'b1;
	logic				slv_first = 1'b1;
	logic				slv_sclk_q = 1'b0;
	int				slv_k = 0;
	int				error_count;
	int				frame_count;
	int				timeout_count;
	int				seed;

	spi_master dut_i (
		.clk		(clk),
		.reset_n	(reset_n),
		.start		(start),
		.bits16		(bits16),
		.mode		(mode),
		.data_in	(data_in),
		.clk_cnt	(clk_cnt),
		.MISO		(MISO),
		.data_out	(data_out),
		.busy		(busy),
		.SEN		(SEN),
		.SCLK		(SCLK),
		.MOSI		(MOSI)
	);

	spi_checker checker_i (
		.clk		(clk),
		.reset_n	(reset_n),
		.start		(start),
		.bits16		(bits16),
		.mode		(mode),
		.data_in	(data_in),
		.clk_cnt	(clk_cnt),
		.data_out	(data_out),
		.exp_resp	(cur_resp),
		.busy		(busy),
		.SEN		(SEN),
		.SCLK		(SCLK),
		.MOSI		(MOSI),
		.error_count	(error_count),
		.frame_count	(frame_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Slave model, updates MISO half a clock after the SCLK edge it follows
	always @(negedge clk) begin : slave_model
		int width;
		int next_k;
		logic lead;
		width = cur_bits16 ? `SPI_DATA_BITS : `SPI_DATA_BITS / 2;
		lead = (slv_sclk_q == cur_mode[1]);
		if (SEN) begin
			slv_k <= 0;
			slv_first <= 1'b1;
			MISO <= cur_resp[width-1];	// MSB ready before the first edge
		end
		else if (SCLK != slv_sclk_q) begin
			if ((!cur_mode[0] && !lead) || (cur_mode[0] && lead && !slv_first)) begin
				next_k = slv_k + 1;
				slv_k <= next_k;
				if (next_k < width)
					MISO <= cur_resp[width-1-next_k];
			end
			if (lead)
				slv_first <= 1'b0;
		end
		slv_sclk_q <= SCLK;
	end

	task automatic fill_table();
		int r;
		tx_tbl = '{16'hA5C3, 16'h00FF, 16'h8001, 16'h1234, 16'h12B7, 16'hFF6D, 16'h0042,
			16'h77C0, 16'h0000};
		resp_tbl = '{16'h3C5A, 16'hF00F, 16'h7FFE, 16'hFEDC, 16'hABE4, 16'h5581, 16'hC399,
			16'h1E2F, 16'h0000};
		mode_tbl = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1, 2'd2, 2'd3, 2'd0};
		bits_tbl = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
		cnt_tbl = '{8'd2, 8'd3, 8'd4, 8'd8, 8'd3, 8'd2, 8'd8, 8'd4, 8'd2};
		tx_tbl[8] = 16'($random(seed));
		resp_tbl[8] = 16'($random(seed));
		mode_tbl[8] = 2'($random(seed));
		bits_tbl[8] = 1'($random(seed));
		r = $random(seed);
		cnt_tbl[8] = 8'(2 + (r & 7));
	endtask

	task automatic run_frame(input int row);
		int waited;
		cur_resp = resp_tbl[row];
		cur_mode = mode_tbl[row];
		cur_bits16 = bits_tbl[row];
		@(posedge clk);
		start <= 1'b1;
		data_in <= tx_tbl[row];
		mode <= mode_tbl[row];
		bits16 <= bits_tbl[row];
		clk_cnt <= cnt_tbl[row];
		@(posedge clk);
		start <= 1'b0;
		waited = 0;
		while (!busy && waited < busy_timeout) begin
			@(posedge clk);
			waited++;
		end
		if (!busy) begin
			$display("Timeout: busy never rose for row %0d", row);
			timeout_count++;
			return;
		end
		repeat (3) @(posedge clk);
		// A start during the frame must not disturb it
		start <= 1'b1;
		data_in <= ~tx_tbl[row];
		mode <= ~mode_tbl[row];
		bits16 <= ~bits_tbl[row];
		clk_cnt <= 8'd5;
		@(posedge clk);
		start <= 1'b0;
		waited = 0;
		while (busy && waited < busy_timeout) begin
			@(posedge clk);
			waited++;
		end
		if (busy) begin
			$display("Timeout: busy stayed high for row %0d", row);
			timeout_count++;
		end
	endtask

	task automatic finish_run();
		$display("Frames: %0d of %0d, errors: %0d, timeouts: %0d",
			frame_count, num_rows, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0 && frame_count == num_rows)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		seed = 64;
		timeout_count = 0;
		reset_n = 1'b0;
		start = 1'b0;
		bits16 = 1'b0;
		mode = 2'b00;
		data_in = '0;
		clk_cnt = 8'd2;
		fill_table();
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < num_rows; i++) begin
			run_frame(i);
			if (timeout_count != 0)
				break;
		end
		repeat (2) @(posedge clk);
		finish_run();
	end

endmodule

// ==== tests/spi_properties.sv ====
`timescale 1ns/100ps

module spi_properties (
	input	logic	clk,
	input	logic	reset_n,
	input	logic	start,
	input	logic	busy,
	input	logic	SEN,
	input	logic	SCLK
);

	// Enable only inside a frame
	sen_within_busy: assert property (@(posedge clk) disable iff (!reset_n)
		!SEN |-> busy)
		else $error("SEN low while busy is low");

	start_sets_busy: assert property (@(posedge clk) disable iff (!reset_n)
		(start && !busy) |=> busy)
		else $error("busy did not rise after start in idle");

	// SCLK only loads CPOL at start and at the SEN rise
	sclk_quiet_when_disabled: assert property (@(posedge clk) disable iff (!reset_n)
		(SEN && $past(SEN) && !$past(start && !busy)) |-> $stable(SCLK))
		else $error("SCLK moved while SEN high");

endmodule

bind spi_master spi_properties props_i (
	.clk		(clk),
	.reset_n	(reset_n),
	.start		(start),
	.busy		(busy),
	.SEN		(SEN),
	.SCLK		(SCLK)
);

// ==== tests/spi_checker.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_checker (
	input	logic				clk,
	input	logic				reset_n,
	input	logic				start,
	input	logic				bits16,
	input	logic [1:0]			mode,
	input	logic [`SPI_DATA_BITS-1:0]	data_in,
	input	logic [`SPI_RATIO_BITS-1:0]	clk_cnt,
	input	logic [`SPI_DATA_BITS-1:0]	data_out,
	input	logic [`SPI_DATA_BITS-1:0]	exp_resp,	// Word the slave sends
	input	logic				busy,
	input	logic				SEN,
	input	logic				SCLK,
	input	logic				MOSI,
	output	int				error_count,
	output	int				frame_count
);

	logic [`SPI_DATA_BITS-1:0]	exp_tx = '0;
	logic [`SPI_DATA_BITS-1:0]	mask = '1;
	logic [`SPI_DATA_BITS-1:0]	captured = '0;	// MOSI bits seen by the slave
	logic				cpol = 1'b0;
	logic				cpha = 1'b0;
	logic				sclk_q = 1'b0;
	logic				sen_q = 1'b1;
	logic				busy_q = 1'b0;
	logic				reset_checked = 1'b0;
	int				width = `SPI_DATA_BITS;
	int				ratio = 2;
	int				lead_cnt = 0;
	int				half_len = 0;
	int				errs = 0;
	int				frames = 0;

	assign error_count = errs;
	assign frame_count = frames;

	task automatic report_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		errs++;
	endtask

	// Frame settings as the DUT latches them
	always @(posedge clk) begin
		if (reset_n && start && !busy) begin
			exp_tx <= data_in;
			cpol <= mode[1];
			cpha <= mode[0];
			width <= bits16 ? `SPI_DATA_BITS : `SPI_DATA_BITS / 2;
			mask <= bits16 ? '1 : `SPI_DATA_BITS'((1 << (`SPI_DATA_BITS / 2)) - 1);
			ratio <= int'(clk_cnt);
		end
	end

	always @(negedge clk) begin
		if (reset_n) begin
			if (!reset_checked) begin
				if (SEN !== 1'b1 || SCLK !== 1'b0 || MOSI !== 1'b0 || busy !== 1'b0)
					report_error("control outputs not idle after reset");
				if (data_out !== '0)
					report_error($sformatf("data_out %h after reset", data_out));
				reset_checked = 1'b1;
			end
			if (sen_q && !SEN) begin
				lead_cnt = 0;	// Frame begins
				half_len = 0;
				captured = '0;
			end
			else if (!SEN) begin
				half_len++;
				if (SCLK != sclk_q) begin
					if (half_len != ratio / 2 && half_len != ratio - ratio / 2)
						report_error($sformatf("SCLK half period %0d cycles, ratio %0d",
							half_len, ratio));
					half_len = 0;
					if (sclk_q == cpol)
						lead_cnt++;
					// Slave samples on the leading edge when CPHA is 0
					if ((sclk_q == cpol) != cpha)
						captured = {captured[`SPI_DATA_BITS-2:0], MOSI};
				end
			end
			if (SEN && SCLK != cpol)
				report_error("SCLK not at CPOL while SEN high");
			if (busy_q && !busy) begin
				frames++;
				if (lead_cnt != width)
					report_error($sformatf("%0d SCLK periods, expected %0d", lead_cnt, width));
				if ((captured & mask) !== (exp_tx & mask))
					report_error($sformatf("MOSI bits %h, expected %h",
						captured & mask, exp_tx & mask));
				if (data_out !== (exp_resp & mask))
					report_error($sformatf("data_out %h, expected %h",
						data_out, exp_resp & mask));
			end
		end
		sclk_q = SCLK;
		sen_q = SEN;
		busy_q = busy;
	end

endmodule

// ==== src/spi_master.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_master (
	input	logic				clk,
	input	logic				reset_n,
	input	logic				start,		// One-cycle strobe, ignored while busy
	input	logic				bits16,		// 1 for a full frame, 0 for half
	input	logic [1:0]			mode,		// CPOL, CPHA
	input	logic [`SPI_DATA_BITS-1:0]	data_in,
	input	logic [`SPI_RATIO_BITS-1:0]	clk_cnt,	// SCLK period in clk cycles
	input	logic				MISO,
	output	logic [`SPI_DATA_BITS-1:0]	data_out,
	output	logic				busy,
	output	logic				SEN,		// Active low enable
	output	logic				SCLK,
	output	logic				MOSI
);

	spi_ctrl_if ctrl_bus ();

	spi_sclk_timer timer_i (
		.clk		(clk),
		.reset_n	(reset_n),
		.clk_cnt	(clk_cnt),
		.ctrl		(ctrl_bus.timer)
	);

	spi_fsm fsm_i (
		.clk		(clk),
		.reset_n	(reset_n),
		.start		(start),
		.bits16		(bits16),
		.mode		(spi_pkg::spi_mode_e'(mode)),
		.ctrl		(ctrl_bus.control),
		.sen		(SEN),
		.sclk		(SCLK),
		.busy		(busy)
	);

	spi_shifter shifter_i (
		.clk		(clk),
		.reset_n	(reset_n),
		.data_in	(data_in),
		.miso		(MISO),
		.ctrl		(ctrl_bus.data),
		.mosi		(MOSI),
		.data_out	(data_out)
	);

endmodule

// ==== src/spi_shifter.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_shifter (
	input	logic				clk,
	input	logic				reset_n,
	input	logic [`SPI_DATA_BITS-1:0]	data_in,
	input	logic				miso,
	spi_ctrl_if.data			ctrl,
	output	logic				mosi,
	output	logic [`SPI_DATA_BITS-1:0]	data_out
);

	logic [`SPI_DATA_BITS-1:0]	tx_word;	// Word being sent

	// Transmit word held for the whole frame
	always_ff @(posedge clk) begin
		if (ctrl.load)
			tx_word <= data_in;
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			mosi <= 1'b0;
		else if (!ctrl.timer_run)
			mosi <= 1'b0;	// Idle low between frames
		else if (ctrl.drive_bit)
			mosi <= tx_word[ctrl.bit_idx];	// MSB first
	end

	// Receive bits land directly in data_out; a half frame leaves the top bits clear
	always_ff @(posedge clk) begin
		if (!reset_n)
			data_out <= '0;
		else if (ctrl.load)
			data_out <= '0;
		else if (ctrl.sample_bit)
			data_out[ctrl.bit_idx] <= miso;
	end

endmodule

// ==== src/spi_fsm.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_fsm (
	input	logic			clk,
	input	logic			reset_n,
	input	logic			start,
	input	logic			bits16,
	input	spi_pkg::spi_mode_e	mode,
	spi_ctrl_if.control		ctrl,
	output	logic			sen,
	output	logic			sclk,
	output	logic			busy
);

	localparam int idx_bits = $clog2(`SPI_DATA_BITS);
	localparam logic [idx_bits-1:0] idx_full = idx_bits'(`SPI_DATA_BITS - 1);
	localparam logic [idx_bits-1:0] idx_half = idx_bits'(`SPI_DATA_BITS / 2 - 1);

	spi_pkg::spi_state_e	state;
	logic			cpol;
	logic			cpha;
	logic [idx_bits-1:0]	bit_idx;
	logic			tick;
	logic			lead_edge;
	logic			sample_now;

	assign tick = ctrl.half_tick | ctrl.end_tick;

	// SCLK still at idle level means the coming toggle is the leading edge
	assign lead_edge = (sclk == cpol);

	// CPHA 0 samples on the leading edge, CPHA 1 on the trailing edge
	assign sample_now = lead_edge ^ cpha;

	assign ctrl.load = (state == spi_pkg::st_idle) && start;
	assign ctrl.timer_run = (state != spi_pkg::st_idle);
	assign ctrl.bit_idx = bit_idx;
	assign ctrl.sample_bit = (state == spi_pkg::st_data) && tick && sample_now;

	// First bit goes out as SEN falls, the rest on the non-sampling edges
	assign ctrl.drive_bit = ((state == spi_pkg::st_setting) && ctrl.half_tick) ||
		((state == spi_pkg::st_data) && tick && !sample_now);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= spi_pkg::st_idle;
			sen <= 1'b1;
			sclk <= 1'b0;
			busy <= 1'b0;
			cpol <= 1'b0;
			cpha <= 1'b0;
			bit_idx <= '0;
		end
		else begin
			case (state)
				spi_pkg::st_idle: begin
					if (start) begin
						busy <= 1'b1;
						cpol <= (mode == spi_pkg::mode_2) || (mode == spi_pkg::mode_3);
						cpha <= (mode == spi_pkg::mode_1) || (mode == spi_pkg::mode_3);
						sclk <= (mode == spi_pkg::mode_2) || (mode == spi_pkg::mode_3);
						bit_idx <= bits16 ? idx_full : idx_half;
						state <= spi_pkg::st_setting;
					end
				end
				spi_pkg::st_setting: begin
					if (ctrl.half_tick) begin
						sen <= 1'b0;	// Frame starts
						state <= spi_pkg::st_data;
					end
				end
				spi_pkg::st_data: begin
					if (tick)
						sclk <= ~sclk;
					if (ctrl.sample_bit) begin
						if (bit_idx == '0)
							state <= spi_pkg::st_stop;	// Last bit captured
						else
							bit_idx <= bit_idx - 1'b1;
					end
				end
				spi_pkg::st_stop: begin
					if (tick) begin
						sen <= 1'b1;
						sclk <= cpol;	// Trailing edge when CPHA is 0
						busy <= 1'b0;
						state <= spi_pkg::st_idle;
					end
				end
				default: state <= spi_pkg::st_idle;
			endcase
		end
	end

endmodule

// ==== src/spi_sclk_timer.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_sclk_timer (
	input	logic				clk,
	input	logic				reset_n,
	input	logic [`SPI_RATIO_BITS-1:0]	clk_cnt,	// SCLK period in clk cycles, >= 2
	spi_ctrl_if.timer			ctrl
);

	logic [`SPI_RATIO_BITS-1:0]	ratio;		// Latched clk_cnt
	logic [`SPI_RATIO_BITS-1:0]	cnt;		// Down counter
	logic [`SPI_RATIO_BITS-1:0]	half_point;

	// Odd ratios round down, so the two halves differ by one cycle
	assign half_point = ratio >> 1;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ratio <= '0;
			cnt <= '0;
		end
		else if (ctrl.load) begin
			ratio <= clk_cnt;
			cnt <= clk_cnt - 1'b1;	// First count is ratio minus one
		end
		else if (ctrl.timer_run) begin
			if (cnt == '0)
				cnt <= ratio - 1'b1;	// Wrap for the next period
			else
				cnt <= cnt - 1'b1;
		end
	end

	// Ticks only while a frame runs
	assign ctrl.half_tick = ctrl.timer_run && (cnt == half_point);
	assign ctrl.end_tick = ctrl.timer_run && (cnt == '0);

endmodule

// ==== src/spi_ctrl_if.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

interface spi_ctrl_if;

	logic					load;		// Start accepted in idle
	logic					timer_run;	// Frame in progress
	logic					half_tick;	// Counter at half the ratio
	logic					end_tick;	// Counter at zero
	logic					drive_bit;	// Put next bit on MOSI
	logic					sample_bit;	// Capture MISO
	logic [$clog2(`SPI_DATA_BITS)-1:0]	bit_idx;	// Current bit position

	modport timer (input load, timer_run, output half_tick, end_tick);

	modport control (output load, timer_run, drive_bit, sample_bit, bit_idx,
		input half_tick, end_tick);

	modport data (input load, timer_run, drive_bit, sample_bit, bit_idx);

endinterface

// ==== src/spi_pkg.sv ====
package spi_pkg;

	// Frame sequencing states
	typedef enum logic [1:0] {
		st_idle    = 2'b00,	// Waiting for start
		st_setting = 2'b01,	// SEN lead-in
		st_data    = 2'b10,	// Bits on the wire
		st_stop    = 2'b11	// SEN tail
	} spi_state_e;

	// Upper bit is CPOL, lower bit is CPHA
	typedef enum logic [1:0] {
		mode_0 = 2'b00,
		mode_1 = 2'b01,
		mode_2 = 2'b10,
		mode_3 = 2'b11
	} spi_mode_e;

endpackage

// ==== include/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Full frame width; a half frame uses the lower half of the word
`define SPI_DATA_BITS 16

// Width of the clk_cnt input and of the SCLK timer counter
`define SPI_RATIO_BITS 8

`endif
